// ==== dcache.f ====
source/dcache_pkg.sv
source/dcache_tag_store.sv
source/dcache_data_store.sv
source/dcache_ctrl.sv
source/dcache_top.sv
sim/dcache_mem_model.sv
sim/dcache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= dcache.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TEST PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	  echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== sim/dcache_tb.sv ====
module dcache_tb
  import dcache_pkg::*;
();

  localparam int                SEED        = 14;
  localparam int                TIMEOUT_CYC = 200;
  localparam logic [ADDR_W-1:0] ERR_BASE    = 32'hF000_0000;
  localparam logic [DATA_W-1:0] INIT_KEY    = 64'h3C96_A55A_0FF0_C3E1;

  logic              clk;
  logic              rst;
  logic              ar_valid_i;
  logic              ar_ready_o;
  logic [ADDR_W-1:0] ar_addr_i;
  logic              r_valid_o;
  logic              r_ready_i;
  logic [DATA_W-1:0] r_data_o;
  logic [1:0]        r_resp_o;
  logic              aw_valid_i;
  logic              aw_ready_o;
  logic [ADDR_W-1:0] aw_addr_i;
  logic              w_valid_i;
  logic              w_ready_o;
  logic [DATA_W-1:0] w_data_i;
  logic [STRB_W-1:0] w_strb_i;
  logic              b_valid_o;
  logic              b_ready_i;
  logic [1:0]        b_resp_o;
  logic              mem_ar_valid_o;
  logic              mem_ar_ready_i;
  logic [ADDR_W-1:0] mem_ar_addr_o;
  logic              mem_r_valid_i;
  logic              mem_r_ready_o;
  logic [DATA_W-1:0] mem_r_data_i;
  logic [1:0]        mem_r_resp_i;
  logic              mem_aw_valid_o;
  logic              mem_aw_ready_i;
  logic [ADDR_W-1:0] mem_aw_addr_o;
  logic              mem_w_valid_o;
  logic              mem_w_ready_i;
  logic [DATA_W-1:0] mem_w_data_o;
  logic [STRB_W-1:0] mem_w_strb_o;
  logic              mem_b_valid_i;
  logic              mem_b_ready_o;
  logic [1:0]        mem_b_resp_i;

  logic [DATA_W-1:0] ref_mem [logic [ADDR_W-1:0]];  // what memory should hold
  int checks   = 0;
  int errors   = 0;
  int timeouts = 0;

  dcache_top u_dut (.*);

  dcache_mem_model #(
    .ERR_BASE (ERR_BASE),
    .INIT_KEY (INIT_KEY)
  ) u_mem (
    .clk            (clk),
    .mem_ar_valid_i (mem_ar_valid_o),
    .mem_ar_ready_o (mem_ar_ready_i),
    .mem_ar_addr_i  (mem_ar_addr_o),
    .mem_r_valid_o  (mem_r_valid_i),
    .mem_r_ready_i  (mem_r_ready_o),
    .mem_r_data_o   (mem_r_data_i),
    .mem_r_resp_o   (mem_r_resp_i),
    .mem_aw_valid_i (mem_aw_valid_o),
    .mem_aw_ready_o (mem_aw_ready_i),
    .mem_aw_addr_i  (mem_aw_addr_o),
    .mem_w_valid_i  (mem_w_valid_o),
    .mem_w_ready_o  (mem_w_ready_i),
    .mem_w_data_i   (mem_w_data_o),
    .mem_w_strb_i   (mem_w_strb_o),
    .mem_b_valid_o  (mem_b_valid_i),
    .mem_b_ready_i  (mem_b_ready_o),
    .mem_b_resp_o   (mem_b_resp_i)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [DATA_W-1:0] merge_bytes(logic [DATA_W-1:0] old,
                                                    logic [DATA_W-1:0] data,
                                                    logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] res;
    res = old;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) res[8*b +: 8] = data[8*b +: 8];
    end
    return res;
  endfunction

  // untouched words hold address pattern
  function automatic logic [DATA_W-1:0] expected_word(logic [ADDR_W-1:0] a);
    return ref_mem.exists(a) ? ref_mem[a] : ({a, a} ^ INIT_KEY);
  endfunction

  task automatic check_value(string name, logic [DATA_W-1:0] exp, logic [DATA_W-1:0] act);
    checks++;
    assert (act === exp)
      else begin
        errors++;
        $display("error %s: expected %h, actual %h", name, exp, act);
      end
  endtask

  task automatic report_timeout(string what, logic [ADDR_W-1:0] addr);
    timeouts++;
    $display("timeout waiting for %s, request address %h", what, addr);
  endtask

  task automatic read_line(input logic [ADDR_W-1:0] addr, input bit bp,
                           output logic [DATA_W-1:0] data, output logic [1:0] resp);
    int n;
    int hold;
    data       = '0;
    resp       = RESP_OKAY;
    ar_addr_i  = addr;
    ar_valid_i = 1'b1;
    n = 0;
    while (!ar_ready_o && n < TIMEOUT_CYC) begin
      @(negedge clk);
      n++;
    end
    if (!ar_ready_o) begin
      ar_valid_i = 1'b0;
      report_timeout("ar_ready_o", addr);
      return;
    end
    @(negedge clk);
    ar_valid_i = 1'b0;
    n = 0;
    while (!r_valid_o && n < TIMEOUT_CYC) begin
      @(negedge clk);
      n++;
    end
    if (!r_valid_o) begin
      report_timeout("r_valid_o", addr);
      return;
    end
    data = r_data_o;
    resp = r_resp_o;
    hold = bp ? $urandom_range(4) : 0;
    repeat (hold) begin
      @(negedge clk);
      checks++;
      assert (r_valid_o && r_data_o === data && r_resp_o === resp)
        else begin
          errors++;
          $display("read response for %h changed while r_ready_i was low", addr);
        end
    end
    r_ready_i = 1'b1;
    @(negedge clk);
    r_ready_i = 1'b0;
  endtask

  task automatic write_line(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            input logic [STRB_W-1:0] strb, input bit bp,
                            output logic [1:0] resp);
    int n;
    int hold;
    resp       = RESP_OKAY;
    aw_addr_i  = addr;
    aw_valid_i = 1'b1;
    w_data_i   = data;
    w_strb_i   = strb;
    w_valid_i  = 1'b1;  // data offered early, taken in S_WDATA
    n = 0;
    while (!aw_ready_o && n < TIMEOUT_CYC) begin
      @(negedge clk);
      n++;
    end
    if (!aw_ready_o) begin
      aw_valid_i = 1'b0;
      w_valid_i  = 1'b0;
      report_timeout("aw_ready_o", addr);
      return;
    end
    @(negedge clk);
    aw_valid_i = 1'b0;
    n = 0;
    while (!w_ready_o && n < TIMEOUT_CYC) begin
      @(negedge clk);
      n++;
    end
    if (!w_ready_o) begin
      w_valid_i = 1'b0;
      report_timeout("w_ready_o", addr);
      return;
    end
    @(negedge clk);
    w_valid_i = 1'b0;
    n = 0;
    while (!b_valid_o && n < TIMEOUT_CYC) begin
      @(negedge clk);
      n++;
    end
    if (!b_valid_o) begin
      report_timeout("b_valid_o", addr);
      return;
    end
    resp = b_resp_o;
    hold = bp ? $urandom_range(4) : 0;
    repeat (hold) begin
      @(negedge clk);
      checks++;
      assert (b_valid_o && b_resp_o === resp)
        else begin
          errors++;
          $display("write response for %h changed while b_ready_i was low", addr);
        end
    end
    b_ready_i = 1'b1;
    @(negedge clk);
    b_ready_i = 1'b0;
  endtask

  task automatic read_check(string name, logic [ADDR_W-1:0] addr, bit bp);
    logic [DATA_W-1:0] data;
    logic [1:0]        resp;
    read_line(addr, bp, data, resp);
    check_value(name, expected_word(addr), data);
    check_value({name, " resp"}, 64'(RESP_OKAY), 64'(resp));
  endtask

  task automatic write_check(string name, logic [ADDR_W-1:0] addr, logic [DATA_W-1:0] data,
                             logic [STRB_W-1:0] strb, bit bp);
    logic [1:0] resp;
    write_line(addr, data, strb, bp, resp);
    ref_mem[addr] = merge_bytes(expected_word(addr), data, strb);
    check_value({name, " resp"}, 64'(RESP_OKAY), 64'(resp));
  endtask

  // second read is served without a fill
  task automatic read_miss_then_hit();
    int fills_before;
    fills_before = u_mem.fill_count;
    read_check("read miss", 32'h0000_4008, 1'b0);
    read_check("read hit", 32'h0000_4008, 1'b0);
    check_value("read hit fill count", 64'(fills_before + 1), 64'(u_mem.fill_count));
  endtask

  task automatic write_hit_merge();
    read_check("write hit prefetch", 32'h0000_5010, 1'b0);
    write_check("write hit", 32'h0000_5010, 64'h1122_3344_5566_7788, 8'h0F, 1'b0);
    read_check("write hit readback", 32'h0000_5010, 1'b0);
  endtask

  task automatic write_allocate_miss();
    write_check("write allocate", 32'h0000_6018, 64'hCAFE_F00D_1234_ABCD, 8'hC3, 1'b0);
    read_check("write allocate readback", 32'h0000_6018, 1'b0);
  endtask

  // A, B and C share set 16
  task automatic dirty_eviction_lru();
    logic [ADDR_W-1:0] a;
    int wb_before;
    a = 32'h0001_0080;
    wb_before = u_mem.wb_count;
    write_check("evict write A", a, 64'hDEAD_BEEF_0BAD_F00D, 8'hF0, 1'b0);
    read_check("evict read B", 32'h0002_0080, 1'b0);
    read_check("evict read C", 32'h0003_0080, 1'b0);
    check_value("evict writeback count", 64'(wb_before + 1), 64'(u_mem.wb_count));
    check_value("evict writeback addr", 64'(a), 64'(u_mem.last_wb_addr));
    check_value("evict writeback data", expected_word(a), u_mem.last_wb_data);
    check_value("evict writeback strobes", 64'({STRB_W{1'b1}}), 64'(u_mem.last_wb_strb));
    read_check("evict reread A", a, 1'b0);
  endtask

  task automatic fill_error_refetch();
    logic [DATA_W-1:0] data;
    logic [1:0]        resp;
    int fills_before;
    fills_before = u_mem.fill_count;
    read_line(ERR_BASE + 32'h20, 1'b0, data, resp);
    check_value("fill error first resp", 64'(RESP_SLVERR), 64'(resp));
    read_line(ERR_BASE + 32'h20, 1'b0, data, resp);
    check_value("fill error second resp", 64'(RESP_SLVERR), 64'(resp));
    check_value("fill error refetch", 64'(fills_before + 2), 64'(u_mem.fill_count));
  endtask

  // 4 tags on sets 5 and 9 so lines get evicted
  task automatic random_mix_backpressure();
    logic [ADDR_W-1:0] addr;
    for (int i = 0; i < 40; i++) begin
      addr = 32'h0010_0000 + ($urandom_range(3) << 12) + ($urandom_range(1) ? 32'h48 : 32'h28);
      if ($urandom_range(1) == 1) begin
        write_check("random write", addr, {$urandom, $urandom}, 8'($urandom_range(255, 1)), 1'b1);
      end else begin
        read_check("random read", addr, 1'b1);
      end
    end
  endtask

  initial begin
    void'($urandom(SEED));
    rst        = 1'b1;
    ar_valid_i = 1'b0;
    ar_addr_i  = '0;
    r_ready_i  = 1'b0;
    aw_valid_i = 1'b0;
    aw_addr_i  = '0;
    w_valid_i  = 1'b0;
    w_data_i   = '0;
    w_strb_i   = '0;
    b_ready_i  = 1'b0;
    repeat (5) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    // readies up, every valid low
    check_value("reset outputs", 64'(7'b1100000),
                64'({ar_ready_o, aw_ready_o, r_valid_o, b_valid_o,
                     mem_ar_valid_o, mem_aw_valid_o, mem_w_valid_o}));
    read_miss_then_hit();
    write_hit_merge();
    write_allocate_miss();
    dirty_eviction_lru();
    fill_error_refetch();
    random_mix_backpressure();
    timeouts += u_mem.stalls;
    $display("%0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== sim/dcache_mem_model.sv ====
module dcache_mem_model
  import dcache_pkg::*;
#(
  parameter logic [ADDR_W-1:0] ERR_BASE = 32'hF000_0000,
  parameter logic [DATA_W-1:0] INIT_KEY = 64'h0
) (
  input  logic              clk,
  input  logic              mem_ar_valid_i,
  output logic              mem_ar_ready_o,
  input  logic [ADDR_W-1:0] mem_ar_addr_i,
  output logic              mem_r_valid_o,
  input  logic              mem_r_ready_i,
  output logic [DATA_W-1:0] mem_r_data_o,
  output logic [1:0]        mem_r_resp_o,
  input  logic              mem_aw_valid_i,
  output logic              mem_aw_ready_o,
  input  logic [ADDR_W-1:0] mem_aw_addr_i,
  input  logic              mem_w_valid_i,
  output logic              mem_w_ready_o,
  input  logic [DATA_W-1:0] mem_w_data_i,
  input  logic [STRB_W-1:0] mem_w_strb_i,
  output logic              mem_b_valid_o,
  input  logic              mem_b_ready_i,
  output logic [1:0]        mem_b_resp_o
);

  localparam int WAIT_MAX = 100;

  logic [DATA_W-1:0] words [logic [ADDR_W-1:0]];  // only written words live here
  int                fill_count   = 0;
  int                wb_count     = 0;
  int                stalls       = 0;
  logic [ADDR_W-1:0] last_wb_addr = '0;
  logic [DATA_W-1:0] last_wb_data = '0;
  logic [STRB_W-1:0] last_wb_strb = '0;

  function automatic logic [DATA_W-1:0] peek(logic [ADDR_W-1:0] a);
    return words.exists(a) ? words[a] : ({a, a} ^ INIT_KEY);
  endfunction

  task automatic ready_delay();
    repeat ($urandom_range(3)) @(negedge clk);
  endtask

  task automatic count_stall(string chan);
    stalls++;
    $display("memory model gave up waiting for %s", chan);
  endtask

  initial begin : read_side
    logic [ADDR_W-1:0] a;
    int n;
    mem_ar_ready_o = 1'b0;
    mem_r_valid_o  = 1'b0;
    mem_r_data_o   = '0;
    mem_r_resp_o   = RESP_OKAY;
    forever begin
      @(negedge clk);
      if (mem_ar_valid_i) begin
        ready_delay();
        a = mem_ar_addr_i;
        mem_ar_ready_o = 1'b1;
        @(negedge clk);
        mem_ar_ready_o = 1'b0;
        fill_count++;
        ready_delay();
        mem_r_valid_o = 1'b1;
        mem_r_resp_o  = (a >= ERR_BASE) ? RESP_SLVERR : RESP_OKAY;
        mem_r_data_o  = (a >= ERR_BASE) ? '0 : peek(a);
        n = 0;
        while (!mem_r_ready_i && n < WAIT_MAX) begin
          @(negedge clk);
          n++;
        end
        if (!mem_r_ready_i) count_stall("mem_r_ready_o");
        else @(negedge clk);  // handshake on the edge in between
        mem_r_valid_o = 1'b0;
      end
    end
  end

  initial begin : write_side
    logic [ADDR_W-1:0] a;
    logic [DATA_W-1:0] d;
    logic [STRB_W-1:0] s;
    int n;
    mem_aw_ready_o = 1'b0;
    mem_w_ready_o  = 1'b0;
    mem_b_valid_o  = 1'b0;
    mem_b_resp_o   = RESP_OKAY;
    forever begin
      @(negedge clk);
      if (mem_aw_valid_i) begin
        ready_delay();
        a = mem_aw_addr_i;
        mem_aw_ready_o = 1'b1;
        @(negedge clk);
        mem_aw_ready_o = 1'b0;
        n = 0;
        while (!mem_w_valid_i && n < WAIT_MAX) begin
          @(negedge clk);
          n++;
        end
        if (!mem_w_valid_i) count_stall("mem_w_valid_o");
        ready_delay();
        d = peek(a);
        s = mem_w_strb_i;
        for (int b = 0; b < STRB_W; b++) begin
          if (s[b]) d[8*b +: 8] = mem_w_data_i[8*b +: 8];
        end
        mem_w_ready_o = 1'b1;
        @(negedge clk);
        mem_w_ready_o = 1'b0;
        words[a]     = d;
        wb_count++;
        last_wb_addr = a;
        last_wb_data = d;
        last_wb_strb = s;
        ready_delay();
        mem_b_valid_o = 1'b1;
        n = 0;
        while (!mem_b_ready_i && n < WAIT_MAX) begin
          @(negedge clk);
          n++;
        end
        if (!mem_b_ready_i) count_stall("mem_b_ready_o");
        else @(negedge clk);
        mem_b_valid_o = 1'b0;
      end
    end
  end

endmodule

// ==== source/dcache_top.sv ====
module dcache_top
  import dcache_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              ar_valid_i,
  output logic              ar_ready_o,
  input  logic [ADDR_W-1:0] ar_addr_i,
  output logic              r_valid_o,
  input  logic              r_ready_i,
  output logic [DATA_W-1:0] r_data_o,
  output logic [1:0]        r_resp_o,
  input  logic              aw_valid_i,
  output logic              aw_ready_o,
  input  logic [ADDR_W-1:0] aw_addr_i,
  input  logic              w_valid_i,
  output logic              w_ready_o,
  input  logic [DATA_W-1:0] w_data_i,
  input  logic [STRB_W-1:0] w_strb_i,
  output logic              b_valid_o,
  input  logic              b_ready_i,
  output logic [1:0]        b_resp_o,
  output logic              mem_ar_valid_o,
  input  logic              mem_ar_ready_i,
  output logic [ADDR_W-1:0] mem_ar_addr_o,
  input  logic              mem_r_valid_i,
  output logic              mem_r_ready_o,
  input  logic [DATA_W-1:0] mem_r_data_i,
  input  logic [1:0]        mem_r_resp_i,
  output logic              mem_aw_valid_o,
  input  logic              mem_aw_ready_i,
  output logic [ADDR_W-1:0] mem_aw_addr_o,
  output logic              mem_w_valid_o,
  input  logic              mem_w_ready_i,
  output logic [DATA_W-1:0] mem_w_data_o,
  output logic [STRB_W-1:0] mem_w_strb_o,
  input  logic              mem_b_valid_i,
  output logic              mem_b_ready_o,
  input  logic [1:0]        mem_b_resp_i
);

  logic [INDEX_W-1:0] lookup_index;
  logic [TAG_W-1:0]   lookup_tag;
  logic               hit;
  logic               hit_way;
  logic               victim_way;
  logic               victim_dirty;
  logic [TAG_W-1:0]   victim_tag;
  logic               upd_en;
  logic               upd_way;
  logic [TAG_W-1:0]   upd_tag;
  logic               upd_valid;
  logic               upd_dirty;
  logic               touch_en;
  logic               ds_rd_en;
  logic               ds_way;
  logic [INDEX_W-1:0] ds_index;
  logic               ds_wr_en;
  logic [STRB_W-1:0]  ds_wr_strb;
  logic [DATA_W-1:0]  ds_wr_data;
  logic [DATA_W-1:0]  ds_rd_data;

  // front and memory ports connect by name
  dcache_ctrl u_ctrl (
    .*,
    .tag_lookup_index_o (lookup_index),
    .tag_lookup_tag_o   (lookup_tag),
    .tag_hit_i          (hit),
    .tag_hit_way_i      (hit_way),
    .tag_victim_way_i   (victim_way),
    .tag_victim_dirty_i (victim_dirty),
    .tag_victim_tag_i   (victim_tag),
    .tag_upd_en_o       (upd_en),
    .tag_upd_way_o      (upd_way),
    .tag_upd_tag_o      (upd_tag),
    .tag_upd_valid_o    (upd_valid),
    .tag_upd_dirty_o    (upd_dirty),
    .tag_touch_en_o     (touch_en),
    .ds_rd_en_o         (ds_rd_en),
    .ds_way_o           (ds_way),
    .ds_index_o         (ds_index),
    .ds_wr_en_o         (ds_wr_en),
    .ds_wr_strb_o       (ds_wr_strb),
    .ds_wr_data_o       (ds_wr_data),
    .rd_data_i          (ds_rd_data)
  );

  dcache_tag_store u_tag_store (
    .clk            (clk),
    .rst            (rst),
    .lookup_index_i (lookup_index),
    .lookup_tag_i   (lookup_tag),
    .hit_o          (hit),
    .hit_way_o      (hit_way),
    .victim_way_o   (victim_way),
    .victim_dirty_o (victim_dirty),
    .victim_tag_o   (victim_tag),
    .upd_en_i       (upd_en),
    .upd_way_i      (upd_way),
    .upd_tag_i      (upd_tag),
    .upd_valid_i    (upd_valid),
    .upd_dirty_i    (upd_dirty),
    .touch_en_i     (touch_en)
  );

  dcache_data_store u_data_store (
    .clk       (clk),
    .rd_en_i   (ds_rd_en),
    .way_i     (ds_way),
    .index_i   (ds_index),
    .wr_en_i   (ds_wr_en),
    .wr_strb_i (ds_wr_strb),
    .wr_data_i (ds_wr_data),
    .rd_data_o (ds_rd_data)
  );

endmodule

// ==== source/dcache_ctrl.sv ====
module dcache_ctrl
  import dcache_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  // requester side
  input  logic               ar_valid_i,
  output logic               ar_ready_o,
  input  logic [ADDR_W-1:0]  ar_addr_i,
  output logic               r_valid_o,
  input  logic               r_ready_i,
  output logic [DATA_W-1:0]  r_data_o,
  output logic [1:0]         r_resp_o,
  input  logic               aw_valid_i,
  output logic               aw_ready_o,
  input  logic [ADDR_W-1:0]  aw_addr_i,
  input  logic               w_valid_i,
  output logic               w_ready_o,
  input  logic [DATA_W-1:0]  w_data_i,
  input  logic [STRB_W-1:0]  w_strb_i,
  output logic               b_valid_o,
  input  logic               b_ready_i,
  output logic [1:0]         b_resp_o,
  // memory side
  output logic               mem_ar_valid_o,
  input  logic               mem_ar_ready_i,
  output logic [ADDR_W-1:0]  mem_ar_addr_o,
  input  logic               mem_r_valid_i,
  output logic               mem_r_ready_o,
  input  logic [DATA_W-1:0]  mem_r_data_i,
  input  logic [1:0]         mem_r_resp_i,
  output logic               mem_aw_valid_o,
  input  logic               mem_aw_ready_i,
  output logic [ADDR_W-1:0]  mem_aw_addr_o,
  output logic               mem_w_valid_o,
  input  logic               mem_w_ready_i,
  output logic [DATA_W-1:0]  mem_w_data_o,
  output logic [STRB_W-1:0]  mem_w_strb_o,
  input  logic               mem_b_valid_i,
  output logic               mem_b_ready_o,
  input  logic [1:0]         mem_b_resp_i,
  // tag store
  output logic [INDEX_W-1:0] tag_lookup_index_o,
  output logic [TAG_W-1:0]   tag_lookup_tag_o,
  input  logic               tag_hit_i,
  input  logic               tag_hit_way_i,
  input  logic               tag_victim_way_i,
  input  logic               tag_victim_dirty_i,
  input  logic [TAG_W-1:0]   tag_victim_tag_i,
  output logic               tag_upd_en_o,
  output logic               tag_upd_way_o,
  output logic [TAG_W-1:0]   tag_upd_tag_o,
  output logic               tag_upd_valid_o,
  output logic               tag_upd_dirty_o,
  output logic               tag_touch_en_o,
  // data store
  output logic               ds_rd_en_o,
  output logic               ds_way_o,
  output logic [INDEX_W-1:0] ds_index_o,
  output logic               ds_wr_en_o,
  output logic [STRB_W-1:0]  ds_wr_strb_o,
  output logic [DATA_W-1:0]  ds_wr_data_o,
  input  logic [DATA_W-1:0]  rd_data_i
);

  ctrl_state_e       state_q;
  ctrl_state_e       state_d;
  acc_kind_e         kind_q;
  logic [ADDR_W-1:0] addr_q;
  logic [ADDR_W-1:0] wb_addr_q;
  logic              vic_way_q;
  logic [DATA_W-1:0] w_data_q;
  logic [STRB_W-1:0] w_strb_q;
  logic [DATA_W-1:0] r_data_q;
  logic [1:0]        resp_q;

  logic ar_hs;
  logic aw_hs;
  logic w_hs;
  logic mem_r_hs;
  logic mem_b_hs;
  logic decide;   // tag result acted on this cycle
  logic fill_ok;
  logic fill_phase;

  assign ar_hs    = ar_valid_i && ar_ready_o;
  assign aw_hs    = aw_valid_i && aw_ready_o;
  assign w_hs     = w_valid_i && w_ready_o;
  assign mem_r_hs = mem_r_valid_i && mem_r_ready_o;
  assign mem_b_hs = mem_b_valid_i && mem_b_ready_o;

  // write hits resolve while the data beat is accepted
  assign decide     = (state_q == S_LOOKUP) || w_hs;
  assign fill_ok    = mem_r_hs && (mem_r_resp_i == RESP_OKAY);
  assign fill_phase = (state_q == S_FILL_R);

  assign ar_ready_o = (state_q == S_IDLE);
  assign aw_ready_o = (state_q == S_IDLE) && !ar_valid_i;  // read wins
  assign w_ready_o  = (state_q == S_WDATA);
  assign r_valid_o  = (state_q == S_RESP_R);
  assign r_data_o   = r_data_q;
  assign r_resp_o   = resp_q;
  assign b_valid_o  = (state_q == S_RESP_B);
  assign b_resp_o   = resp_q;

  assign mem_ar_valid_o = (state_q == S_FILL_AR);
  assign mem_ar_addr_o  = {addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
  assign mem_r_ready_o  = fill_phase;
  assign mem_aw_valid_o = (state_q == S_WB_AW);
  assign mem_aw_addr_o  = wb_addr_q;
  assign mem_w_valid_o  = (state_q == S_WB_W);
  assign mem_w_data_o   = rd_data_i;  // victim word stays in the read register
  assign mem_w_strb_o   = '1;
  assign mem_b_ready_o  = (state_q == S_WB_B);

  assign tag_lookup_index_o = addr_q[OFFSET_W +: INDEX_W];
  assign tag_lookup_tag_o   = addr_q[ADDR_W-1 -: TAG_W];
  assign tag_upd_en_o       = (decide && tag_hit_i && kind_q == ACC_WRITE) || mem_b_hs || fill_ok;
  assign tag_upd_way_o      = (decide && tag_hit_i) ? tag_hit_way_i : vic_way_q;
  assign tag_upd_tag_o      = addr_q[ADDR_W-1 -: TAG_W];
  assign tag_upd_valid_o    = (state_q != S_WB_B);  // written back victim drops out
  assign tag_upd_dirty_o    = decide;
  assign tag_touch_en_o     = decide && tag_hit_i;

  assign ds_index_o   = addr_q[OFFSET_W +: INDEX_W];
  assign ds_rd_en_o   = decide && (tag_hit_i ? (kind_q == ACC_READ) : tag_victim_dirty_i);
  assign ds_wr_en_o   = (decide && tag_hit_i && kind_q == ACC_WRITE) || fill_ok;
  assign ds_way_o     = fill_phase ? vic_way_q : (tag_hit_i ? tag_hit_way_i : tag_victim_way_i);
  assign ds_wr_strb_o = fill_phase ? '1 : ((state_q == S_WDATA) ? w_strb_i : w_strb_q);
  assign ds_wr_data_o = fill_phase ? mem_r_data_i :
                        ((state_q == S_WDATA) ? w_data_i : w_data_q);

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (ar_hs) state_d = S_LOOKUP;
        else if (aw_hs) state_d = S_WDATA;
      end
      S_WDATA, S_LOOKUP: begin
        if (decide) begin
          if (tag_hit_i && kind_q == ACC_READ) state_d = S_RDATA;
          else if (tag_hit_i) state_d = S_RESP_B;
          else if (tag_victim_dirty_i) state_d = S_WB_AW;
          else state_d = S_FILL_AR;
        end
      end
      S_RDATA:   state_d = S_RESP_R;
      S_RESP_R:  if (r_ready_i) state_d = S_IDLE;
      S_RESP_B:  if (b_ready_i) state_d = S_IDLE;
      S_WB_AW:   if (mem_aw_ready_i) state_d = S_WB_W;
      S_WB_W:    if (mem_w_ready_i) state_d = S_WB_B;
      S_WB_B:    if (mem_b_valid_i) state_d = S_FILL_AR;
      S_FILL_AR: if (mem_ar_ready_i) state_d = S_FILL_R;
      S_FILL_R: begin
        if (fill_ok) state_d = S_LOOKUP;  // replay hits now
        else if (mem_r_hs && kind_q == ACC_READ) state_d = S_RESP_R;
        else if (mem_r_hs) state_d = S_RESP_B;
      end
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      addr_q <= ar_addr_i;
      kind_q <= ACC_READ;
      resp_q <= RESP_OKAY;
    end else if (aw_hs) begin
      addr_q <= aw_addr_i;
      kind_q <= ACC_WRITE;
      resp_q <= RESP_OKAY;
    end
    if (w_hs) begin
      w_data_q <= w_data_i;
      w_strb_q <= w_strb_i;
    end
    if (decide && !tag_hit_i) begin
      vic_way_q <= tag_victim_way_i;
      wb_addr_q <= {tag_victim_tag_i, addr_q[OFFSET_W +: INDEX_W], {OFFSET_W{1'b0}}};
    end
    if (state_q == S_RDATA) begin
      r_data_q <= rd_data_i;
    end
    if (mem_b_hs && mem_b_resp_i != RESP_OKAY) begin
      resp_q <= RESP_SLVERR;  // victim lost, flag it on the reply
    end
    if (mem_r_hs && !fill_ok) begin
      resp_q   <= RESP_SLVERR;
      r_data_q <= '0;
    end
  end

  assert property (@(posedge clk) disable iff (rst)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_data_o))
    else $error("r_valid_o dropped before accept on %s", kind_q.name());

  assert property (@(posedge clk) disable iff (rst)
    mem_aw_valid_o && !mem_aw_ready_i |=> mem_aw_valid_o && $stable(mem_aw_addr_o))
    else $error("writeback aw dropped during %s miss", kind_q.name());

endmodule

// ==== source/dcache_data_store.sv ====
module dcache_data_store
  import dcache_pkg::*;
(
  input  logic               clk,
  input  logic               rd_en_i,
  input  logic               way_i,
  input  logic [INDEX_W-1:0] index_i,
  input  logic               wr_en_i,
  input  logic [STRB_W-1:0]  wr_strb_i,
  input  logic [DATA_W-1:0]  wr_data_i,
  output logic [DATA_W-1:0]  rd_data_o
);

  logic [DATA_W-1:0] line_q [WAYS][SETS];

  // byte merge on write
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (wr_strb_i[b]) begin
          line_q[way_i][index_i][8*b +: 8] <= wr_data_i[8*b +: 8];
        end
      end
    end
  end

  // read data holds until the next read
  always_ff @(posedge clk) begin
    if (rd_en_i) begin
      rd_data_o <= line_q[way_i][index_i];
    end
  end

  // controller never reads and writes the store in one cycle
  assert property (@(posedge clk) !(rd_en_i && wr_en_i))
    else $error("data store read and write in the same cycle");

endmodule

// ==== source/dcache_tag_store.sv ====
module dcache_tag_store
  import dcache_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic [INDEX_W-1:0] lookup_index_i,
  input  logic [TAG_W-1:0]   lookup_tag_i,
  output logic               hit_o,
  output logic               hit_way_o,
  output logic               victim_way_o,
  output logic               victim_dirty_o,
  output logic [TAG_W-1:0]   victim_tag_o,
  input  logic               upd_en_i,
  input  logic               upd_way_i,
  input  logic [TAG_W-1:0]   upd_tag_i,
  input  logic               upd_valid_i,
  input  logic               upd_dirty_i,
  input  logic               touch_en_i
);

  logic [TAG_W-1:0] tag_q [WAYS][SETS];
  logic [SETS-1:0]  valid_q [WAYS];
  logic [SETS-1:0]  dirty_q [WAYS];
  logic [SETS-1:0]  lru_q;  // holds the least recently used way
  logic [WAYS-1:0]  way_hit;

  always_comb begin
    for (int w = 0; w < WAYS; w++) begin
      way_hit[w] = valid_q[w][lookup_index_i] && (tag_q[w][lookup_index_i] == lookup_tag_i);
    end
  end

  assign hit_o     = |way_hit;
  assign hit_way_o = way_hit[1];

  // invalid way first, else lru
  assign victim_way_o = !valid_q[0][lookup_index_i] ? 1'b0 :
                        !valid_q[1][lookup_index_i] ? 1'b1 : lru_q[lookup_index_i];

  assign victim_dirty_o = valid_q[victim_way_o][lookup_index_i] &&
                          dirty_q[victim_way_o][lookup_index_i];
  assign victim_tag_o   = tag_q[victim_way_o][lookup_index_i];

  always_ff @(posedge clk) begin
    if (upd_en_i) begin
      tag_q[upd_way_i][lookup_index_i] <= upd_tag_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int w = 0; w < WAYS; w++) begin
        valid_q[w] <= '0;
        dirty_q[w] <= '0;
      end
      lru_q <= '0;
    end else begin
      if (upd_en_i) begin
        valid_q[upd_way_i][lookup_index_i] <= upd_valid_i;
        dirty_q[upd_way_i][lookup_index_i] <= upd_dirty_i;
      end
      if (touch_en_i) begin
        lru_q[lookup_index_i] <= ~hit_way_o;  // other way becomes lru
      end
    end
  end

  // fill only ever targets a way that missed, so a tag lives in one way
  assert property (@(posedge clk) disable iff (rst) !(way_hit[0] && way_hit[1]))
    else $error("tag hit on both ways at set %0d", lookup_index_i);

endmodule

// ==== source/dcache_pkg.sv ====
package dcache_pkg;

  // address split is tag | index | offset
  localparam int ADDR_W   = 32;
  localparam int DATA_W   = 64;
  localparam int STRB_W   = DATA_W / 8;
  localparam int OFFSET_W = 3;
  localparam int INDEX_W  = 6;
  localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

  localparam int SETS = 1 << INDEX_W;
  localparam int WAYS = 2;  // way number is one bit

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  typedef enum logic [3:0] {
    S_IDLE,
    S_LOOKUP,
    S_RDATA,
    S_WDATA,
    S_RESP_R,
    S_RESP_B,
    S_WB_AW,    // victim writeback
    S_WB_W,
    S_WB_B,
    S_FILL_AR,  // line fill
    S_FILL_R
  } ctrl_state_e;

  typedef enum logic {
    ACC_READ,
    ACC_WRITE
  } acc_kind_e;

endpackage
